// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk
);

    localparam real PERIOD_NS = 40.0;

    initial
    begin
        clk = 1'b0;
    end

    // Free running, half period high and half low
    always
    begin
        #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

// ==== bench/tb_host_chan_events.sv ====
`timescale 1ns/1ps

`include "host_events_defines.svh"

module tb_host_chan_events;

    import tlp_hdr_pkg::*;
    import host_events_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int RUN_CYCLES = 3000;
    // Margin over reset, directed and flush cycles
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + 1000;
    localparam int DW = `HOST_EVENTS_TDATA_WIDTH;

    logic clk;
    logic reset_n;
    logic en_tx;
    logic [DW-1:0] tx_data;
    logic tx_tlast;
    logic en_tx_b;
    logic [DW-1:0] tx_b_data;
    logic tx_b_tlast;
    logic en_rx;
    logic [DW-1:0] rx_data;
    logic rx_tlast;
    logic events_clear;
    t_event_total rd_req_total;
    t_event_total rd_rsp_total;
    t_event_total rd_outstanding;
    t_event_total rd_outstanding_max;

    // Reference model state
    logic model_sop [3];
    t_dword_count req_pipe [$];
    t_dword_count rsp_pipe [$];
    t_event_total exp_req_total;
    t_event_total exp_rsp_total;
    t_event_total exp_outstanding;
    t_event_total exp_outstanding_max;

    // Remaining beats of the packet each stream is sending
    int beats_left [3];
    int cycle_count;
    string test_name;

    tb_clock_gen clock0
    (
        .clk (clk)
    );

    host_chan_events_top dut0
    (
        .clk                (clk),
        .reset_n            (reset_n),
        .en_tx              (en_tx),
        .tx_data            (tx_data),
        .tx_tlast           (tx_tlast),
        .en_tx_b            (en_tx_b),
        .tx_b_data          (tx_b_data),
        .tx_b_tlast         (tx_b_tlast),
        .en_rx              (en_rx),
        .rx_data            (rx_data),
        .rx_tlast           (rx_tlast),
        .events_clear       (events_clear),
        .rd_req_total       (rd_req_total),
        .rd_rsp_total       (rd_rsp_total),
        .rd_outstanding     (rd_outstanding),
        .rd_outstanding_max (rd_outstanding_max)
    );

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // fmt_type sits at 63:56 and length at 41:32
    function automatic logic [63:0] build_header(input logic [7:0] fmt, input logic [9:0] len);
        return {fmt, 14'h0, len, 32'h0};
    endfunction

    function automatic logic [63:0] random_header(input logic is_rx);
        logic [7:0] fmt;
        logic [9:0] len;
        int kind;
        int len_kind;
        kind = $urandom_range(7, 0);
        if (!is_rx)
            fmt = (kind < 3) ? 8'h00 : (kind < 5) ? 8'h20 : (kind == 5) ? 8'h40 :
                  (kind == 6) ? 8'h4A : 8'($urandom);
        else
            fmt = (kind < 4) ? 8'h4A : (kind == 4) ? 8'h0A : (kind == 5) ? 8'h40 :
                  (kind == 6) ? 8'h00 : 8'($urandom);
        len_kind = $urandom_range(7, 0);
        if (len_kind == 0)
            len = 10'd0;
        else if (len_kind < 4)
            len = 10'($urandom_range(16, 1));
        else
            len = 10'($urandom_range(1023, 0));
        return build_header(fmt, len) | {8'h0, 14'($urandom), 10'h0, 32'($urandom)};
    endfunction

    function automatic logic [DW-1:0] random_word();
        logic [DW-1:0] word;
        for (int i = 0; i < DW / 32; i++)
            word[i*32 +: 32] = $urandom;
        return word;
    endfunction

    function automatic t_dword_count request_dwords(input logic en, input logic sop,
                                                    input logic [DW-1:0] data);
        if (en && sop && func_is_mrd_req(data[63:56]))
            return t_dword_count'(func_length_dwords(data[41:32]));
        return '0;
    endfunction

    function automatic t_dword_count completion_dwords(input logic en, input logic sop,
                                                       input logic [DW-1:0] data);
        if (en && sop && func_is_completion(data[63:56]) && func_has_data(data[63:56]))
            return t_dword_count'(func_length_dwords(data[41:32]));
        return '0;
    endfunction

    task automatic compare_value(input string name, input t_event_total expected,
                                 input t_event_total actual);
        if (expected !== actual)
        begin
            $display("error: %s %s expected %h actual %h", test_name, name, expected, actual);
            $display("Test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic check_outputs();
        compare_value("rd_req_total", exp_req_total, rd_req_total);
        compare_value("rd_rsp_total", exp_rsp_total, rd_rsp_total);
        compare_value("rd_outstanding", exp_outstanding, rd_outstanding);
        compare_value("rd_outstanding_max", exp_outstanding_max, rd_outstanding_max);
    endtask

    // One clock edge of the model on the inputs held across that edge
    task automatic model_step();
        t_dword_count req_now;
        t_dword_count rsp_now;
        t_dword_count req_old;
        t_dword_count rsp_old;
        req_now = request_dwords(en_tx, model_sop[0], tx_data) +
                  request_dwords(en_tx_b, model_sop[1], tx_b_data);
        rsp_now = completion_dwords(en_rx, model_sop[2], rx_data);
        req_old = req_pipe.pop_front();
        rsp_old = rsp_pipe.pop_front();
        req_pipe.push_back(req_now);
        rsp_pipe.push_back(rsp_now);
        if (events_clear)
        begin
            exp_req_total = '0;
            exp_rsp_total = '0;
            exp_outstanding = '0;
            exp_outstanding_max = '0;
        end
        else
        begin
            exp_req_total = exp_req_total + t_event_total'(req_old);
            exp_rsp_total = exp_rsp_total + t_event_total'(rsp_old);
            // Outstanding is the difference of the two totals
            exp_outstanding = exp_req_total - exp_rsp_total;
            if (exp_outstanding > exp_outstanding_max)
                exp_outstanding_max = exp_outstanding;
        end
        if (en_tx)
            model_sop[0] = tx_tlast;
        if (en_tx_b)
            model_sop[1] = tx_b_tlast;
        if (en_rx)
            model_sop[2] = rx_tlast;
    endtask

    task automatic advance_cycle();
        @(posedge clk);
        #2;
        model_step();
        check_outputs();
    endtask

    task automatic idle_inputs();
        en_tx = 1'b0;
        en_tx_b = 1'b0;
        en_rx = 1'b0;
        tx_tlast = 1'b0;
        tx_b_tlast = 1'b0;
        rx_tlast = 1'b0;
        tx_data = '0;
        tx_b_data = '0;
        rx_data = '0;
        events_clear = 1'b0;
    endtask

    // Disabled beats also carry headers and a random last flag
    task automatic make_beat(input int s, output logic en, output logic [DW-1:0] data,
                             output logic last);
        data = random_word();
        en = ($urandom_range(3, 0) != 0);
        last = 1'($urandom_range(1, 0));
        if (en)
        begin
            if (beats_left[s] == 0)
            begin
                beats_left[s] = $urandom_range(4, 1);
                data[63:0] = random_header(s == 2);
            end
            else if ($urandom_range(3, 0) == 0)
            begin
                data[63:0] = random_header(s == 2);
            end
            last = (beats_left[s] == 1);
            beats_left[s]--;
        end
        else if ($urandom_range(1, 0) == 1)
        begin
            data[63:0] = random_header(s == 2);
        end
    endtask

    initial
    begin
        void'($urandom(32'h3555_eaf5));
        reset_n = 1'b0;
        idle_inputs();
        cycle_count = 0;
        for (int s = 0; s < 3; s++)
        begin
            model_sop[s] = 1'b1;
            beats_left[s] = 0;
        end
        req_pipe.push_back('0);
        rsp_pipe.push_back('0);
        exp_req_total = '0;
        exp_rsp_total = '0;
        exp_outstanding = '0;
        exp_outstanding_max = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset_n = 1'b1;
        test_name = "reset";
        check_outputs();

        test_name = "directed";
        // Both transmit pipes in one cycle with a zero length meaning 1024
        en_tx = 1'b1;
        tx_data = build_header(8'h00, 10'd0);
        tx_tlast = 1'b1;
        en_tx_b = 1'b1;
        tx_b_data = build_header(8'h20, 10'd7);
        tx_b_tlast = 1'b1;
        advance_cycle();
        idle_inputs();
        en_rx = 1'b1;
        rx_data = build_header(8'h4A, 10'd5);
        rx_tlast = 1'b1;
        en_tx = 1'b1;
        tx_data = build_header(8'h40, 10'd9);
        tx_tlast = 1'b1;
        advance_cycle();
        idle_inputs();
        en_rx = 1'b1;
        rx_data = build_header(8'h0A, 10'd3);
        rx_tlast = 1'b1;
        en_tx = 1'b1;
        tx_data = build_header(8'h00, 10'd2);
        advance_cycle();
        // Middle beat with a read header is not a start of packet
        idle_inputs();
        en_tx = 1'b1;
        tx_data = build_header(8'h00, 10'd9);
        tx_tlast = 1'b1;
        advance_cycle();
        idle_inputs();
        en_tx = 1'b1;
        tx_data = build_header(8'h00, 10'd4);
        tx_tlast = 1'b1;
        advance_cycle();
        // Clear lands on the edge that delivers the previous count
        idle_inputs();
        events_clear = 1'b1;
        advance_cycle();
        idle_inputs();
        repeat (3) advance_cycle();

        test_name = "random";
        repeat (RUN_CYCLES)
        begin
            make_beat(0, en_tx, tx_data, tx_tlast);
            make_beat(1, en_tx_b, tx_b_data, tx_b_tlast);
            make_beat(2, en_rx, rx_data, rx_tlast);
            events_clear = ($urandom_range(149, 0) == 0);
            advance_cycle();
        end
        idle_inputs();
        repeat (3) advance_cycle();

        $display("Test passed");
        $finish;
    end

endmodule

// ==== common/host_chan_events_if.sv ====
`timescale 1ns/1ps

interface host_chan_events_if;

    import host_events_pkg::*;

    // Restart all counts
    logic clear;

    t_event_total rd_req_total;
    t_event_total rd_rsp_total;
    t_event_total rd_outstanding;
    t_event_total rd_outstanding_max;

    // Event tracker side
    modport monitor
    (
        input  clear,
        output rd_req_total,
        output rd_rsp_total,
        output rd_outstanding,
        output rd_outstanding_max
    );

    // Consumer side
    modport engine
    (
        output clear,
        input  rd_req_total,
        input  rd_rsp_total,
        input  rd_outstanding,
        input  rd_outstanding_max
    );

endinterface

// ==== common/host_events_defines.svh ====
`ifndef HOST_EVENTS_DEFINES_SVH
`define HOST_EVENTS_DEFINES_SVH

// Width of one stream data beat
`define HOST_EVENTS_TDATA_WIDTH 256

// TLP header sits in the low bits of the first beat
`define HOST_EVENTS_HDR_WIDTH 64

// Dwords counted in one cycle, both transmit pipes together
`define HOST_EVENTS_DW_CNT_WIDTH 14

// Running totals
`define HOST_EVENTS_TOTAL_WIDTH 40

`endif

// ==== common/host_events_pkg.sv ====
`include "host_events_defines.svh"

package host_events_pkg;

    // Dwords seen in a single cycle
    typedef logic [`HOST_EVENTS_DW_CNT_WIDTH-1:0] t_dword_count;

    // Accumulated dword totals, wrap modulo 2**40
    typedef logic [`HOST_EVENTS_TOTAL_WIDTH-1:0] t_event_total;

endpackage

// ==== common/tlp_hdr_pkg.sv ====
package tlp_hdr_pkg;

    // Memory request header, first two dwords
    typedef struct packed {
        logic [7:0]  fmt_type;
        logic [13:0] reserved;
        logic [9:0]  length;
        logic [15:0] requester_id;
        logic [7:0]  tag;
        logic [7:0]  addr_lo;
    } t_tlp_mem_req_hdr;

    // Completion header, first two dwords
    typedef struct packed {
        logic [7:0]  fmt_type;
        logic [13:0] reserved;
        logic [9:0]  length;
        logic [15:0] completer_id;
        logic [11:0] byte_count;
        logic [3:0]  tag;
    } t_tlp_cpl_hdr;

    // Same header word, read as a request on transmit and as a completion on receive
    typedef union packed {
        t_tlp_mem_req_hdr req;
        t_tlp_cpl_hdr     cpl;
    } t_tlp_hdr_u;

    // MRd with 32 or 64 bit address
    function automatic logic func_is_mrd_req(input logic [7:0] fmt_type);
        return (fmt_type == 8'h00) || (fmt_type == 8'h20);
    endfunction

    function automatic logic func_is_completion(input logic [7:0] fmt_type);
        return (fmt_type[4:0] == 5'h0A);
    endfunction

    function automatic logic func_has_data(input logic [7:0] fmt_type);
        return fmt_type[6];
    endfunction

    // Length field of zero encodes 1024 dwords
    function automatic logic [10:0] func_length_dwords(input logic [9:0] length);
        logic [10:0] n_dwords;
        if (length == 10'd0)
        begin
            n_dwords = 11'd1024;
        end
        else
        begin
            n_dwords = {1'b0, length};
        end
        return n_dwords;
    endfunction

endpackage

// ==== design/host_chan_events_top.sv ====
`timescale 1ns/1ps

`include "host_events_defines.svh"

module host_chan_events_top
(
    input  logic clk,
    input  logic reset_n,

    input  logic en_tx,
    input  logic [`HOST_EVENTS_TDATA_WIDTH-1:0] tx_data,
    input  logic tx_tlast,

    input  logic en_tx_b,
    input  logic [`HOST_EVENTS_TDATA_WIDTH-1:0] tx_b_data,
    input  logic tx_b_tlast,

    input  logic en_rx,
    input  logic [`HOST_EVENTS_TDATA_WIDTH-1:0] rx_data,
    input  logic rx_tlast,

    input  logic events_clear,

    output host_events_pkg::t_event_total rd_req_total,
    output host_events_pkg::t_event_total rd_rsp_total,
    output host_events_pkg::t_event_total rd_outstanding,
    output host_events_pkg::t_event_total rd_outstanding_max
);

    host_chan_events_if events0();

    // Engine side of the events interface
    assign events0.clear = events_clear;
    assign rd_req_total = events0.rd_req_total;
    assign rd_rsp_total = events0.rd_rsp_total;
    assign rd_outstanding = events0.rd_outstanding;
    assign rd_outstanding_max = events0.rd_outstanding_max;

    host_chan_events_axi axi0
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .en_tx      (en_tx),
        .tx_data    (tx_data),
        .tx_tlast   (tx_tlast),
        .en_tx_b    (en_tx_b),
        .tx_b_data  (tx_b_data),
        .tx_b_tlast (tx_b_tlast),
        .en_rx      (en_rx),
        .rx_data    (rx_data),
        .rx_tlast   (rx_tlast),
        .events     (events0.monitor)
    );

endmodule

// ==== host_chan_events/host_chan_events_axi.sv ====
`timescale 1ns/1ps

`include "host_events_defines.svh"

module host_chan_events_axi
(
    input  logic clk,
    input  logic reset_n,

    input  logic en_tx,
    input  logic [`HOST_EVENTS_TDATA_WIDTH-1:0] tx_data,
    input  logic tx_tlast,

    input  logic en_tx_b,
    input  logic [`HOST_EVENTS_TDATA_WIDTH-1:0] tx_b_data,
    input  logic tx_b_tlast,

    input  logic en_rx,
    input  logic [`HOST_EVENTS_TDATA_WIDTH-1:0] rx_data,
    input  logic rx_tlast,

    host_chan_events_if.monitor events
);

    import tlp_hdr_pkg::*;
    import host_events_pkg::*;

    t_tlp_hdr_u tx_hdr;
    t_tlp_hdr_u tx_b_hdr;
    t_tlp_hdr_u rx_hdr;

    logic tx_sop;
    logic tx_b_sop;
    logic rx_sop;

    t_dword_count rd_n_dwords_req;
    t_dword_count b_pipe_rd_n_dwords_req;
    t_dword_count rd_n_dwords_rsp;
    t_dword_count rd_n_dwords_req_q;
    t_dword_count rd_n_dwords_rsp_q;

    // Header is only meaningful on a start-of-packet beat
    always_comb
    begin
        tx_hdr = tx_data[`HOST_EVENTS_HDR_WIDTH-1:0];
        tx_b_hdr = tx_b_data[`HOST_EVENTS_HDR_WIDTH-1:0];
        rx_hdr = rx_data[`HOST_EVENTS_HDR_WIDTH-1:0];
    end

    // Next enabled beat starts a packet when the last one closed it
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            tx_sop <= 1'b1;
            tx_b_sop <= 1'b1;
            rx_sop <= 1'b1;
        end
        else
        begin
            if (en_tx)
                tx_sop <= tx_tlast;
            if (en_tx_b)
                tx_b_sop <= tx_b_tlast;
            if (en_rx)
                rx_sop <= rx_tlast;
        end
    end

    // Read requests from both transmit pipes
    always_comb
    begin
        rd_n_dwords_req = '0;
        if (en_tx && tx_sop && func_is_mrd_req(tx_hdr.req.fmt_type))
            rd_n_dwords_req = t_dword_count'(func_length_dwords(tx_hdr.req.length));

        b_pipe_rd_n_dwords_req = '0;
        if (en_tx_b && tx_b_sop && func_is_mrd_req(tx_b_hdr.req.fmt_type))
            b_pipe_rd_n_dwords_req = t_dword_count'(func_length_dwords(tx_b_hdr.req.length));
    end

    // Completions carrying read data
    always_comb
    begin
        rd_n_dwords_rsp = '0;
        if (en_rx && rx_sop &&
            func_is_completion(rx_hdr.cpl.fmt_type) &&
            func_has_data(rx_hdr.cpl.fmt_type))
        begin
            rd_n_dwords_rsp = t_dword_count'(func_length_dwords(rx_hdr.cpl.length));
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_n_dwords_req_q <= '0;
            rd_n_dwords_rsp_q <= '0;
        end
        else
        begin
            rd_n_dwords_req_q <= rd_n_dwords_req + b_pipe_rd_n_dwords_req;
            rd_n_dwords_rsp_q <= rd_n_dwords_rsp;
        end
    end

    host_chan_events_common common0
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .rd_req_cnt (rd_n_dwords_req_q),
        .rd_rsp_cnt (rd_n_dwords_rsp_q),
        .events     (events)
    );

endmodule

// ==== host_chan_events/host_chan_events_common.sv ====
`timescale 1ns/1ps

module host_chan_events_common
(
    input  logic clk,
    input  logic reset_n,

    // Dwords seen in the previous cycle
    input  host_events_pkg::t_dword_count rd_req_cnt,
    input  host_events_pkg::t_dword_count rd_rsp_cnt,

    host_chan_events_if.monitor events
);

    import host_events_pkg::*;

    t_event_total req_total;
    t_event_total rsp_total;
    t_event_total outstanding;
    t_event_total outstanding_max;

    t_event_total outstanding_next;

    // New outstanding value, wraps with the totals
    always_comb
    begin
        outstanding_next = outstanding + t_event_total'(rd_req_cnt) -
                           t_event_total'(rd_rsp_cnt);
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            req_total <= '0;
            rsp_total <= '0;
            outstanding <= '0;
            outstanding_max <= '0;
        end
        else if (events.clear)
        begin
            // Counts arriving with the clear are dropped
            req_total <= '0;
            rsp_total <= '0;
            outstanding <= '0;
            outstanding_max <= '0;
        end
        else
        begin
            req_total <= req_total + t_event_total'(rd_req_cnt);
            rsp_total <= rsp_total + t_event_total'(rd_rsp_cnt);
            outstanding <= outstanding_next;

            // Peak tracks the value being written this cycle
            if (outstanding_next > outstanding_max)
                outstanding_max <= outstanding_next;
        end
    end

    assign events.rd_req_total = req_total;
    assign events.rd_rsp_total = rsp_total;
    assign events.rd_outstanding = outstanding;
    assign events.rd_outstanding_max = outstanding_max;

endmodule

// ==== tb.f ====
+incdir+common
common/tlp_hdr_pkg.sv
common/host_events_pkg.sv
common/host_chan_events_if.sv
host_chan_events/host_chan_events_common.sv
host_chan_events/host_chan_events_axi.sv
design/host_chan_events_top.sv
bench/tb_clock_gen.sv
bench/tb_host_chan_events.sv
